/* verilog/rtg_defines.svh */
// Sizes for the RTG display path. FIFO depth must stay a power of two
// and the request level must be below the depth.
`ifndef RTG_DEFINES_SVH
`define RTG_DEFINES_SVH

// Stream FIFO
`define RTG_FIFO_AW        5  // 32 words
`define RTG_FIFO_REQ_LEVEL 16 // Ask for more below this fill

// Palette
`define RTG_CLUT_AW        8  // 256 entries

`endif

/* verilog/rtg_pkg.sv */
// Shared types for the RTG display path. Struct field order is fixed,
// the testbench packs stimulus words in this order.
`default_nettype none

`include "rtg_defines.svh"

package rtg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Plain vectors
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [15:0]               stream_word_t; // 0RRRRRGGGGGBBBBB or two indices
  typedef logic [`RTG_CLUT_AW-1:0]   clut_idx_t;    // Palette index
  typedef logic [3:0]                pixel_width_t; // Clocks per fetch - 1
  typedef logic [6:0]                vb_count_t;    // Line count
  typedef logic [`RTG_FIFO_AW:0]     fifo_level_t;  // One extra bit for full

  ////////////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // Chipset timing, all active high except syncs as delivered
  typedef struct packed {
    logic hs;
    logic vs;
    logic cs;
    logic hblank;
    logic vblank;
  } video_timing_t;

  typedef struct packed {
    logic         ena;         // RTG on
    logic         clut;        // Palette mode
    logic         ext;         // Extend active area one clock
    pixel_width_t pixel_width;
    vb_count_t    vb_end;      // Lines of blank after vblank
  } rtg_cfg_t;

  typedef struct packed {
    logic      en;  // One-cycle write strobe
    clut_idx_t idx;
    rgb_t      rgb;
  } clut_wr_t;

endpackage

`default_nettype wire

/* verilog/rtg_pixel_timer.sv */
// Fetch rhythm for the RTG path. cfg must be static during a frame.
// Vertical blank ends by counting hs rising edges, not from the chipset.
`timescale 1ns/1ps
`default_nettype none

module rtg_pixel_timer (
  input  logic                   CLK_114,
  input  logic                   rst_n,
  input  rtg_pkg::video_timing_t timing,
  input  rtg_pkg::rtg_cfg_t      cfg,
  output logic                   pixel_rd,  // Pop strobe to FIFO
  output logic                   rtg_blank, // RTG picture blanked
  output logic                   byte_sel,  // Low byte index when high
  output logic                   flush      // Empty FIFO, block fill
);

  rtg_pkg::pixel_width_t pix_cnt;    // Clocks since last fetch
  rtg_pkg::pixel_width_t half_width; // Point to switch byte
  rtg_pkg::vb_count_t    vb_cnt;     // Lines since vblank fell
  logic                  vblank_q;   // Line-counted vertical blank
  logic                  blank_d;    // Blank one clock ago
  logic                  blank_rise;
  logic                  sel_q;      // Second half of fetch reached
  logic                  sel_d;      // Aligned to palette lookup
  logic                  hs_d;       // For edge detect
  logic                  hs_rise;

  assign rtg_blank  = vblank_q | timing.hblank;
  assign blank_rise = rtg_blank & ~blank_d;        // Blank just started
  assign hs_rise    = timing.hs & ~hs_d;
  assign half_width = {1'b0, cfg.pixel_width[3:1]};
  assign byte_sel   = sel_d;
  assign flush      = timing.vblank | ~cfg.ena;    // Restart stream each frame

  // Fetch when counter hits width, one extra fetch at blank start if ext
  assign pixel_rd = cfg.ena & (~rtg_blank | (blank_rise & cfg.ext)) &
                    (pix_cnt == cfg.pixel_width);

  ////////////////////////////////////////////////////////////////////////////
  // Fetch counter and byte select
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114 or negedge rst_n) begin
    if (!rst_n) begin
      pix_cnt <= '0;
      sel_q   <= 1'b0;
      sel_d   <= 1'b0;
      blank_d <= 1'b0;
    end else begin
      blank_d <= rtg_blank;
      sel_d   <= sel_q;                 // One clock late, matches head timing
      if (rtg_blank || pixel_rd) begin
        pix_cnt <= '0;                  // Restart each word and in blank
        sel_q   <= 1'b0;
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
        if (pix_cnt == half_width)
          sel_q <= 1'b1;                // Halfway, move to low byte
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Vertical blank by line count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114 or negedge rst_n) begin
    if (!rst_n) begin
      vblank_q <= 1'b0;
      vb_cnt   <= '0;
      hs_d     <= 1'b0;
    end else begin
      hs_d <= timing.hs;
      if (timing.vblank) begin
        vblank_q <= 1'b1;               // Hold blank through chipset vblank
        vb_cnt   <= '0;
      end else if (vb_cnt == cfg.vb_end) begin
        vblank_q <= 1'b0;               // Enough lines, open picture
      end else if (hs_rise) begin
        vb_cnt <= vb_cnt + 1'b1;        // One per line
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/rtg_stream_fifo.sv */
// Word FIFO between memory and the mixer. head shows the oldest word
// without a read and reads zero when empty. A fill while full is dropped.
`timescale 1ns/1ps
`default_nettype none

`include "rtg_defines.svh"

module rtg_stream_fifo (
  input  logic                  CLK_114,
  input  logic                  rst_n,
  input  logic                  flush,     // Empties buffer, blocks fill
  input  logic                  fill,      // Push strobe
  input  rtg_pkg::stream_word_t fill_data,
  input  logic                  pixel_rd,  // Pop strobe
  output rtg_pkg::stream_word_t head,      // Oldest word
  output rtg_pkg::fifo_level_t  level,
  output logic                  fill_req   // More words wanted
);

  localparam int unsigned DEPTH = 1 << `RTG_FIFO_AW;
  localparam rtg_pkg::fifo_level_t FULL_LEVEL = rtg_pkg::fifo_level_t'(DEPTH);
  localparam rtg_pkg::fifo_level_t REQ_LEVEL  =
    rtg_pkg::fifo_level_t'(`RTG_FIFO_REQ_LEVEL);

  rtg_pkg::stream_word_t   mem [0:DEPTH-1]; // Word storage
  logic [`RTG_FIFO_AW-1:0] wr_ptr;
  logic [`RTG_FIFO_AW-1:0] rd_ptr;
  rtg_pkg::fifo_level_t    level_nxt;
  logic                    push;
  logic                    pop;

  assign push = fill & ~flush & (level != FULL_LEVEL); // Drop when full
  assign pop  = pixel_rd & (level != '0);              // Empty read is a no-op
  assign head = (level != '0) ? mem[rd_ptr] : '0;

  always_comb begin
    level_nxt = level;
    if (flush) begin
      level_nxt = '0;
    end else begin
      case ({push, pop})
        2'b10:   level_nxt = level + 1'b1;
        2'b01:   level_nxt = level - 1'b1;
        default: level_nxt = level;    // Both or neither
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers, level and request
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114 or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      level    <= '0;
      fill_req <= 1'b0;
    end else begin
      level    <= level_nxt;
      fill_req <= ~flush & (level_nxt < REQ_LEVEL); // Tracks level register
      if (flush) begin
        wr_ptr <= '0;                  // Drop everything
        rd_ptr <= '0;
      end else begin
        if (push)
          wr_ptr <= wr_ptr + 1'b1;     // Wraps at depth
        if (pop)
          rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge CLK_114) begin
    if (push)
      mem[wr_ptr] <= fill_data;
  end

endmodule

`default_nettype wire

/* verilog/rtg_pixel_mixer.sv */
// Colour path to the video pins. Palette is flops, read asynchronously.
// OSD levels are registered with the colour so all outputs lag one clock.
`timescale 1ns/1ps
`default_nettype none

`include "rtg_defines.svh"

module rtg_pixel_mixer (
  input  logic                   CLK_114,
  input  logic                   rst_n,
  input  rtg_pkg::rtg_cfg_t      cfg,
  input  rtg_pkg::clut_wr_t      clut_wr,    // Host palette write
  input  rtg_pkg::stream_word_t  head,       // Current FIFO word
  input  logic                   rtg_blank,
  input  logic                   byte_sel,   // 0 = high byte index
  input  rtg_pkg::video_timing_t timing,     // Chipset timing
  input  rtg_pkg::rgb_t          chip_rgb,   // Chipset colour
  input  logic                   osd_window,
  input  logic                   osd_pixel,
  output rtg_pkg::video_timing_t vga_timing,
  output rtg_pkg::rgb_t          vga_rgb
);

  localparam int unsigned CLUT_SIZE = 1 << `RTG_CLUT_AW;

  rtg_pkg::rgb_t          palette [0:CLUT_SIZE-1];
  rtg_pkg::clut_idx_t     clut_idx;
  rtg_pkg::rgb_t          clut_rgb;   // Palette colour
  rtg_pkg::rgb_t          hi_rgb;     // Expanded 5-5-5 colour
  rtg_pkg::rgb_t          mix_rgb;    // Selected before register
  rtg_pkg::rgb_t          rgb_q;
  rtg_pkg::video_timing_t timing_q;
  logic                   rtg_sel;
  logic                   osd_window_q;
  logic                   osd_pixel_q;
  logic [1:0]             osd_r;
  logic [1:0]             osd_g;
  logic [1:0]             osd_b;

  // 5 bit to 8 bit, top bits repeated so full scale stays full scale
  function automatic logic [7:0] expand5(input logic [4:0] c);
    return {c, c[4:2]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Palette
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114) begin
    if (clut_wr.en)
      palette[clut_wr.idx] <= clut_wr.rgb; // Visible next clock
  end

  assign clut_idx = byte_sel ? head[7:0] : head[15:8]; // High byte first
  assign clut_rgb = palette[clut_idx];

  ////////////////////////////////////////////////////////////////////////////
  // Colour select
  ////////////////////////////////////////////////////////////////////////////

  assign hi_rgb.r = expand5(head[14:10]);
  assign hi_rgb.g = expand5(head[9:5]);
  assign hi_rgb.b = expand5(head[4:0]);

  assign rtg_sel = cfg.ena & ~rtg_blank;   // Else chipset shows through

  always_comb begin
    if (!rtg_sel)
      mix_rgb = chip_rgb;
    else if (cfg.clut)
      mix_rgb = clut_rgb;
    else
      mix_rgb = hi_rgb;
  end

  // Output register, timing rides along
  always_ff @(posedge CLK_114 or negedge rst_n) begin
    if (!rst_n) begin
      rgb_q        <= '0;
      timing_q     <= '0;
      osd_window_q <= 1'b0;
      osd_pixel_q  <= 1'b0;
    end else begin
      rgb_q        <= mix_rgb;
      timing_q     <= timing;
      osd_window_q <= osd_window;
      osd_pixel_q  <= osd_pixel;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // OSD overlay
  ////////////////////////////////////////////////////////////////////////////

  // White text on a dim blue tint
  assign osd_r = osd_pixel_q ? 2'b11 : 2'b00;
  assign osd_g = osd_pixel_q ? 2'b11 : 2'b00;
  assign osd_b = osd_pixel_q ? 2'b11 : 2'b10;

  assign vga_rgb.r  = osd_window_q ? {osd_r, rgb_q.r[7:2]} : rgb_q.r;
  assign vga_rgb.g  = osd_window_q ? {osd_g, rgb_q.g[7:2]} : rgb_q.g;
  assign vga_rgb.b  = osd_window_q ? {osd_b, rgb_q.b[7:2]} : rgb_q.b;
  assign vga_timing = timing_q;

endmodule

`default_nettype wire

/* verilog/rtg_video_top.sv */
// RTG display path. Word producer must honour fill_req, a fill into a
// full FIFO is lost. cfg is held static for a whole frame.
`timescale 1ns/1ps
`default_nettype none

module rtg_video_top (
  input  logic                   CLK_114,
  input  logic                   rst_n,
  input  rtg_pkg::video_timing_t timing,     // From chipset
  input  rtg_pkg::rgb_t          chip_rgb,
  input  logic                   osd_window,
  input  logic                   osd_pixel,
  input  rtg_pkg::rtg_cfg_t      cfg,
  input  rtg_pkg::clut_wr_t      clut_wr,
  input  logic                   fill,       // Word strobe from memory
  input  rtg_pkg::stream_word_t  fill_data,
  output logic                   fill_req,   // Level, ask for words
  output rtg_pkg::video_timing_t vga_timing,
  output rtg_pkg::rgb_t          vga_rgb
);

  logic                  pixel_rd;  // Pop one word
  logic                  rtg_blank;
  logic                  byte_sel;
  logic                  flush;
  rtg_pkg::stream_word_t head;      // Oldest word to mixer

  rtg_pixel_timer timer_i (
    .CLK_114   (CLK_114),
    .rst_n     (rst_n),
    .timing    (timing),
    .cfg       (cfg),
    .pixel_rd  (pixel_rd),
    .rtg_blank (rtg_blank),
    .byte_sel  (byte_sel),
    .flush     (flush)
  );

  rtg_stream_fifo fifo_i (
    .CLK_114   (CLK_114),
    .rst_n     (rst_n),
    .flush     (flush),
    .fill      (fill),
    .fill_data (fill_data),
    .pixel_rd  (pixel_rd),
    .head      (head),
    .level     (),             // Fill count not needed by the mixer
    .fill_req  (fill_req)
  );

  rtg_pixel_mixer mixer_i (
    .CLK_114    (CLK_114),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .clut_wr    (clut_wr),
    .head       (head),
    .rtg_blank  (rtg_blank),
    .byte_sel   (byte_sel),
    .timing     (timing),
    .chip_rgb   (chip_rgb),
    .osd_window (osd_window),
    .osd_pixel  (osd_pixel),
    .vga_timing (vga_timing),
    .vga_rgb    (vga_rgb)
  );

endmodule

`default_nettype wire

/* tb/rtg_video_properties.sv */
// FIFO rules for the RTG stream. Bound into every rtg_stream_fifo.
// The word producer must honour fill_req and must stay quiet during flush.
`timescale 1ns/1ps
`default_nettype none

`include "rtg_defines.svh"

module rtg_video_properties (
  input logic                 CLK_114,
  input logic                 rst_n,
  input logic                 fill,
  input logic                 flush,
  input logic                 pixel_rd,
  input rtg_pkg::fifo_level_t level
);

  localparam rtg_pkg::fifo_level_t DEPTH = rtg_pkg::fifo_level_t'(1 << `RTG_FIFO_AW);

  int fail_count = 0; // Failed assertions so far

  // A word pushed into a full or flushing FIFO is lost
  fill_accepted: assert property (@(posedge CLK_114) disable iff (!rst_n)
    fill |-> (!flush && level != DEPTH))
    else begin
      $error("fill while FIFO full or flushing");
      fail_count++;
    end

  level_in_range: assert property (@(posedge CLK_114) disable iff (!rst_n)
    level <= DEPTH)
    else begin
      $error("FIFO level above depth");
      fail_count++;
    end

  // pixel_rd only fires in active display, so an empty read is an underrun
  no_underrun: assert property (@(posedge CLK_114) disable iff (!rst_n)
    pixel_rd |-> level != '0)
    else begin
      $error("pixel read from empty FIFO");
      fail_count++;
    end

endmodule

bind rtg_stream_fifo rtg_video_properties props_i (
  .CLK_114  (CLK_114),
  .rst_n    (rst_n),
  .fill     (fill),
  .flush    (flush),
  .pixel_rd (pixel_rd),
  .level    (level)
);

`default_nettype wire

/* tb/rtg_video_tb.sv */
// Testbench for the RTG display path. Commands come from tb/rtg_video_tests.txt,
// run from the project root. Chipset colours are pseudo random, hs runs free
// with a 20 clock line. Words are pushed by a model producer that obeys fill_req.
`timescale 1ns/1ps
`default_nettype none

module rtg_video_tb;

  localparam string TEST_FILE = "tb/rtg_video_tests.txt";

  logic                   CLK_114;
  logic                   rst_n;
  rtg_pkg::video_timing_t timing;
  rtg_pkg::video_timing_t vga_timing;
  rtg_pkg::video_timing_t prev_timing; // Inputs seen at the last edge
  rtg_pkg::rgb_t          chip_rgb;
  rtg_pkg::rgb_t          vga_rgb;
  rtg_pkg::rgb_t          prev_chip;
  logic                   osd_window;
  logic                   osd_pixel;
  logic                   prev_win;
  logic                   prev_pix;
  rtg_pkg::rtg_cfg_t      cfg;
  rtg_pkg::clut_wr_t      clut_wr;
  logic                   fill;
  logic                   fill_req;
  rtg_pkg::stream_word_t  fill_data;
  rtg_pkg::stream_word_t  fill_q[$];   // Words waiting for the producer
  logic [31:0]            lcg_state;
  int                     hs_phase;
  int                     hs_rises;    // hs rises since vblank fell
  logic                   hs_last;     // hs at the previous edge
  int                     q_tn[$];     // Parsed command lines
  logic [7:0]             q_cmd[$];
  logic [31:0]            q_a[$];
  logic [31:0]            q_b[$];
  logic [31:0]            q_c[$];
  logic [31:0]            q_d[$];
  logic [31:0]            q_e[$];
  int                     n_lines;     // Lines in the command file
  int                     errors;
  int                     test_errs;
  int                     tests_run;
  int                     tests_failed;
  int                     cur_test;
  bit                     loaded;

  rtg_video_top dut_i (
    .CLK_114    (CLK_114),
    .rst_n      (rst_n),
    .timing     (timing),
    .chip_rgb   (chip_rgb),
    .osd_window (osd_window),
    .osd_pixel  (osd_pixel),
    .cfg        (cfg),
    .clut_wr    (clut_wr),
    .fill       (fill),
    .fill_data  (fill_data),
    .fill_req   (fill_req),
    .vga_timing (vga_timing),
    .vga_rgb    (vga_rgb)
  );

  initial begin
    CLK_114 = 1'b0;
    forever #5 CLK_114 = ~CLK_114;              // 100 MHz stand-in
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // OSD window rule, top two bits replaced, colour shifted down
  function automatic rtg_pkg::rgb_t osd_apply(input rtg_pkg::rgb_t c, input logic win,
                                              input logic pix);
    rtg_pkg::rgb_t o;
    o = c;
    if (win) begin
      o.r = {(pix ? 2'b11 : 2'b00), c.r[7:2]};
      o.g = {(pix ? 2'b11 : 2'b00), c.g[7:2]};
      o.b = {(pix ? 2'b11 : 2'b10), c.b[7:2]};
    end
    return o;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Chipset model and word producer
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge CLK_114) begin
    prev_chip   <= chip_rgb;                   // What the DUT registers now
    prev_timing <= timing;
    prev_win    <= osd_window;
    prev_pix    <= osd_pixel;
    lcg_state = next_rand(lcg_state);
    chip_rgb  <= lcg_state[31:8];
    hs_phase  = (hs_phase + 1) % 20;
    timing.hs <= (hs_phase < 2);               // Two clock sync pulse
    timing.vs <= lcg_state[7];                 // Pass-through only
    timing.cs <= lcg_state[6];
    if (timing.vblank)
      hs_rises = 0;
    else if (timing.hs && !hs_last)
      hs_rises++;                              // Rise seen at this edge
    hs_last = timing.hs;
    if (fill_q.size() != 0 && fill_req && !timing.vblank) begin
      fill      <= 1'b1;
      fill_data <= fill_q.pop_front();
    end else begin
      fill <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic log_error(input string what, input logic [31:0] exp,
                           input logic [31:0] got);
    $display("error %s expected %h got %h", what, exp, got);
    errors++;
    test_errs++;
  endtask

  task automatic log_problem(input string msg);
    $display("%s", msg);
    errors++;
    test_errs++;
  endtask

  task automatic check_bypass();
    rtg_pkg::rgb_t exp;
    exp = osd_apply(prev_chip, prev_win, prev_pix);
    if (vga_rgb !== exp)
      log_error("vga_rgb", exp, vga_rgb);
  endtask

  task automatic run_bypass(input int n);
    repeat (n) begin
      @(negedge CLK_114);
      check_bypass();
      if (vga_timing !== prev_timing)
        log_error("vga_timing", prev_timing, vga_timing);
    end
  endtask

  // hold 0 checks order only, else chipset until shown, then exact hold
  task automatic wait_colour(input rtg_pkg::rgb_t target, input int hold);
    rtg_pkg::rgb_t exp;
    int            waited;
    int            cnt;
    exp    = osd_apply(target, osd_window, osd_pixel);
    waited = 0;
    while (vga_rgb !== exp && waited < 500) begin
      if (hold != 0)
        check_bypass();
      @(negedge CLK_114);
      waited++;
    end
    if (vga_rgb !== exp) begin
      log_problem($sformatf("colour %h never appeared on vga_rgb", target));
    end else if (hold != 0) begin
      cnt = 0;
      while (vga_rgb === exp && cnt < 500) begin
        cnt++;
        @(negedge CLK_114);
      end
      if (cnt != hold)
        log_problem($sformatf("colour %h held for %0d cycles instead of %0d",
                              target, cnt, hold));
    end
  endtask

  task automatic wait_fill_drain();
    while (fill_q.size() != 0)
      @(negedge CLK_114);
  endtask

  task automatic set_blank(input logic h, input logic v);
    wait_fill_drain();
    @(posedge CLK_114);
    timing.hblank <= h;
    timing.vblank <= v;
    @(negedge CLK_114);
  endtask

  task automatic pulse_vblank(input int n);
    wait_fill_drain();
    repeat (2) @(posedge CLK_114);              // Let the last push land
    @(posedge CLK_114);
    timing.vblank <= 1'b1;
    @(posedge CLK_114);
    timing.hblank <= 1'b0;                      // Line count alone blanks now
    repeat (n) begin
      @(negedge CLK_114);
      if (fill_req !== 1'b0)
        log_problem("fill_req stayed high during vblank");
    end
    @(posedge CLK_114);
    timing.vblank <= 1'b0;
    @(negedge CLK_114);
  endtask

  task automatic count_lines(input int n);
    int waited;
    waited = 0;
    while (hs_rises < n && waited < 2000) begin
      check_bypass();
      @(negedge CLK_114);
      waited++;
    end
    if (hs_rises < n)
      log_problem("hs edges never counted up after vblank");
  endtask

  task automatic finish_test();
    if (cur_test != 0) begin
      $display("test %0d done, %0d errors", cur_test, test_errs);
      tests_run++;
      if (test_errs != 0)
        tests_failed++;
    end
    test_errs = 0;
  endtask

  task automatic load_tests();
    int          fd;
    int          code;
    int          tn;
    string       line;
    logic [7:0]  cmd;
    logic [31:0] a, b, c, d, e;
    fd = $fopen(TEST_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0)
          n_lines++;
        if (code > 1 && line.getc(0) != "#") begin
          if ($sscanf(line, "%d %c %h %h %h %h %h", tn, cmd, a, b, c, d, e) == 7) begin
            q_tn.push_back(tn);
            q_cmd.push_back(cmd);
            q_a.push_back(a);
            q_b.push_back(b);
            q_c.push_back(c);
            q_d.push_back(d);
            q_e.push_back(e);
          end
        end
      end
      $fclose(fd);
      loaded = (q_tn.size() != 0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n       = 1'b0;
    timing      = '0;
    chip_rgb    = '0;
    prev_timing = '0;
    prev_chip   = '0;
    prev_win    = 1'b0;
    prev_pix    = 1'b0;
    osd_window  = 1'b0;
    osd_pixel   = 1'b0;
    cfg         = '0;
    clut_wr     = '0;
    fill        = 1'b0;
    fill_data   = '0;
    lcg_state   = 32'h1b19_7769;
    hs_phase    = 0;
    hs_rises    = 0;
    hs_last     = 1'b0;
    n_lines     = 0;
    errors      = 0;
    test_errs   = 0;
    tests_run   = 0;
    tests_failed = 0;
    cur_test    = 0;
    loaded      = 1'b0;
    load_tests();
    if (!loaded) begin
      $display("could not read any commands from %s", TEST_FILE);
      $display("tests failed");
      $finish;
    end else begin
      repeat (10) @(posedge CLK_114);
      rst_n <= 1'b1;
      @(negedge CLK_114);
      for (int i = 0; i < q_tn.size(); i++) begin
        if (q_tn[i] != cur_test) begin
          finish_test();
          cur_test = q_tn[i];
        end
        case (q_cmd[i])
          "R": begin
            @(posedge CLK_114);
            cfg.ena         <= q_a[i][0];
            cfg.clut        <= q_b[i][0];
            cfg.ext         <= q_c[i][0];
            cfg.pixel_width <= q_d[i][3:0];
            cfg.vb_end      <= q_e[i][6:0];
            @(negedge CLK_114);
          end
          "P": begin
            @(posedge CLK_114);
            clut_wr <= {1'b1, q_a[i][7:0], q_b[i][23:0]};
            @(posedge CLK_114);
            clut_wr.en <= 1'b0;
            @(negedge CLK_114);
          end
          "F": fill_q.push_back(q_a[i][15:0]);
          "B": set_blank(q_a[i][0], q_b[i][0]);
          "O": begin
            @(posedge CLK_114);
            osd_window <= q_a[i][0];
            osd_pixel  <= q_b[i][0];
            @(negedge CLK_114);
          end
          "Y": run_bypass(q_a[i]);
          "Q": begin
            @(posedge CLK_114);
            @(negedge CLK_114);
            if (fill_req !== q_a[i][0])
              log_error("fill_req", q_a[i][0], fill_req);
          end
          "V": pulse_vblank(q_a[i]);
          "H": count_lines(q_a[i]);
          "W": wait_colour(q_a[i][23:0], q_b[i]);
          default: log_problem($sformatf("unknown command on line %0d", i + 1));
        endcase
      end
      finish_test();
      errors += dut_i.fifo_i.props_i.fail_count;  // FIFO assertion failures
      $display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
        $display("all tests passed");
      else
        $display("tests failed");
      $finish;
    end
  end

  // Watchdog sized from the file length
  initial begin
    wait (loaded);
    repeat (n_lines * 200) @(posedge CLK_114);
    $display("run did not finish in time, stopped by watchdog");
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/rtg_video_tests.txt */
# test cmd a b c d e, all fields hex, unused ones 0
# R ena clut ext width vb_end | P idx rgb | F word | B hblank vblank | O window pixel
# Y cycles | Q fill_req | V cycles | H hs_edges | W rgb hold (hold 0 = order only)
1 R 0 0 0 5 3
1 Y 40 0 0 0 0
2 O 1 1 0 0 0
2 Y 20 0 0 0 0
2 O 1 0 0 0 0
2 Y 20 0 0 0 0
2 O 0 0 0 0 0
3 B 1 0 0 0 0
3 R 1 0 0 5 3
3 Q 1 0 0 0 0
3 F 7FFF 0 0 0 0
3 F 7C00 0 0 0 0
3 F 03E0 0 0 0 0
3 F 001F 0 0 0 0
3 F 4210 0 0 0 0
3 B 0 0 0 0 0
3 W FFFFFF 6 0 0 0
3 W FF0000 6 0 0 0
3 W 00FF00 6 0 0 0
3 W 0000FF 6 0 0 0
3 W 848484 6 0 0 0
3 B 1 0 0 0 0
4 O 1 1 0 0 0
4 F 7C00 0 0 0 0
4 F 001F 0 0 0 0
4 B 0 0 0 0 0
4 W FF0000 6 0 0 0
4 W 0000FF 6 0 0 0
4 B 1 0 0 0 0
4 O 1 0 0 0 0
4 F 03E0 0 0 0 0
4 B 0 0 0 0 0
4 W 00FF00 6 0 0 0
4 B 1 0 0 0 0
4 O 0 0 0 0 0
5 R 1 1 0 5 3
5 P 00 102030 0 0 0
5 P 11 AA0000 0 0 0
5 P 22 00BB00 0 0 0
5 P 33 0000CC 0 0 0
5 P 44 DDDD00 0 0 0
5 F 1122 0 0 0 0
5 F 3344 0 0 0 0
5 B 0 0 0 0 0
5 W AA0000 0 0 0 0
5 W 00BB00 0 0 0 0
5 W 0000CC 0 0 0 0
5 W DDDD00 0 0 0 0
5 B 1 0 0 0 0
6 R 1 0 0 5 3
6 F 7FFF 0 0 0 0
6 F 7FFF 0 0 0 0
6 V 8 0 0 0 0
6 F 7C00 0 0 0 0
6 F 03E0 0 0 0 0
6 H 3 0 0 0 0
6 W FF0000 6 0 0 0
6 W 00FF00 6 0 0 0
6 B 1 0 0 0 0

/* files.f */
+incdir+verilog
verilog/rtg_pkg.sv
verilog/rtg_pixel_timer.sv
verilog/rtg_stream_fifo.sv
verilog/rtg_pixel_mixer.sv
verilog/rtg_video_top.sv
tb/rtg_video_properties.sv
tb/rtg_video_tb.sv
